// ==== logic/inmux_pkg.sv ====
/*
 * Definitions shared by the input mux, the interrupt bits and the testbench.
 * Import with a wildcard inside a module body, or use scoped names in headers.
 */
package inmux_pkg;

   // ==================================================
   // Widths
   // ==================================================

   localparam int DATA_W = 32; // Bus and datapath width

   // ==================================================
   // Region select on adr[29:27]
   // ==================================================

   // Low half reads the external input port
   // Upper half reads the machine interrupt registers
   typedef enum logic [2:0] {
      IO0     = 3'b000,
      IO1     = 3'b001,
      IO2     = 3'b010,
      IO3     = 3'b011,
      MIP_ALT = 3'b100, // Spare code, decodes as MIP
      MIP     = 3'b101,
      MIE     = 3'b110,
      MSTATUS = 3'b111
   } sysreg_sel_e;

   // ==================================================
   // Bit positions in MIP, MIE and MSTATUS
   // ==================================================

   localparam int BIT_SW     = 3;  // Software irq, mie in MSTATUS
   localparam int BIT_TIMER  = 7;  // Timer irq, mpie in MSTATUS
   localparam int BIT_EXT    = 11; // External irq
   localparam int BIT_TICK   = 16; // Time increment event
   localparam int BIT_RETIRE = 17; // Instruction retired event

   // Bits 11 and 12 of MSTATUS always read as one
   // (MPP fixed to machine mode)
   localparam logic [DATA_W-1:0] MSTATUS_FIXED = 32'h0000_1800;

endpackage

// ==== logic/irq_csr_bits.sv ====
/*
 * Machine interrupt state behind MIP, MIE and MSTATUS.
 * Takes write-backs already acknowledged by the input mux, latches tick and
 * retire events and produces a registered interrupt request.
 */
`timescale 1ns/1ps

module irq_csr_bits (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       sysregack,    // Access to a system register
   input  logic                       we,           // Write strobe
   input  logic [1:0]                 adr,          // adr[28:27] of the core
   input  logic [inmux_pkg::DATA_W-1:0] wdat,       // Write data
   input  logic                       irq_ext,      // External interrupt level
   input  logic                       irq_timer,    // Timer interrupt level
   input  logic                       tick_pulse,   // One-cycle time increment event
   input  logic                       retire_pulse, // One-cycle retire event
   output logic                       mie,          // MSTATUS global enable
   output logic                       mpie,         // MSTATUS previous enable
   output logic                       msie,
   output logic                       mtie,
   output logic                       meie,
   output logic                       mtimeincie,
   output logic                       mrinstretie,
   output logic                       msip,
   output logic                       mtip,
   output logic                       meip,
   output logic                       mtimeincip,
   output logic                       mrinstretip,
   output logic                       irq_pending   // Registered request to the core
);
   import inmux_pkg::*;

   sysreg_sel_e wsel;    // Register targeted by the write
   logic        wr_en;   // Acknowledged write
   logic        mip_wr;  // Write to MIP or its alias
   logic        any_pend;

   // Only codes 1xx give sysregack, so bit 29 is implied
   assign wsel   = sysreg_sel_e'({1'b1, adr});
   assign wr_en  = sysregack & we;
   assign mip_wr = wr_en & ((wsel == MIP) | (wsel == MIP_ALT));

   // Pending and enabled, per source
   assign any_pend = (msip        & msie)
                   | (mtip        & mtie)
                   | (meip        & meie)
                   | (mtimeincip  & mtimeincie)
                   | (mrinstretip & mrinstretie);

   // ==================================================
   // Register state
   // ==================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         mie         <= 1'b0;
         mpie        <= 1'b0;
         msie        <= 1'b0;
         mtie        <= 1'b0;
         meie        <= 1'b0;
         mtimeincie  <= 1'b0;
         mrinstretie <= 1'b0;
         msip        <= 1'b0;
         mtip        <= 1'b0;
         meip        <= 1'b0;
         mtimeincip  <= 1'b0;
         mrinstretip <= 1'b0;
         irq_pending <= 1'b0;
      end else begin
         mtip <= irq_timer; // Level sources, writes ignored
         meip <= irq_ext;

         if (wr_en) begin
            case (wsel)
               MIP_ALT, MIP: msip <= wdat[BIT_SW];
               MIE: begin
                  msie        <= wdat[BIT_SW];
                  mtie        <= wdat[BIT_TIMER];
                  meie        <= wdat[BIT_EXT];
                  mtimeincie  <= wdat[BIT_TICK];
                  mrinstretie <= wdat[BIT_RETIRE];
               end
               MSTATUS: begin
                  mie  <= wdat[BIT_SW];
                  mpie <= wdat[BIT_TIMER];
               end
               default: ; // IO codes never reach here
            endcase
         end

         // Event bits are set by hardware, cleared by writing zero
         if (tick_pulse)
            mtimeincip <= 1'b1; // Set wins over clear
         else if (mip_wr && !wdat[BIT_TICK])
            mtimeincip <= 1'b0;

         if (retire_pulse)
            mrinstretip <= 1'b1;
         else if (mip_wr && !wdat[BIT_RETIRE])
            mrinstretip <= 1'b0;

         irq_pending <= mie & any_pend; // One cycle behind the bits
      end
   end

endmodule

// ==== logic/data_sram.sv ====
/*
 * Small synchronous word SRAM on the core bus.
 * A strobe sampled at one edge gives the read word and the acknowledge in
 * the following cycle. Writes take effect at the strobe edge.
 */
`timescale 1ns/1ps

module data_sram #(
   parameter int SRAM_ADR_W = 6 // Word address bits from 4 to 10
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         sram_stb, // Access request
   input  logic                         we,       // Write when strobed
   input  logic [SRAM_ADR_W-1:0]        adr,      // Word address
   input  logic [inmux_pkg::DATA_W-1:0] wdat,     // Write data
   output logic [inmux_pkg::DATA_W-1:0] dsram,    // Read word valid with sram_ack
   output logic                         sram_ack  // One cycle after sram_stb
);

   localparam int DEPTH = 2 ** SRAM_ADR_W;

   // ==================================================
   // Storage
   // ==================================================

   logic [inmux_pkg::DATA_W-1:0] mem [DEPTH]; // Infers block RAM

   // Memory contents survive reset
   always_ff @(posedge clk) begin
      if (sram_stb && we)
         mem[adr] <= wdat;
   end

   // Read port is registered and returns the old word on a write
   always_ff @(posedge clk) begin
      if (reset)
         dsram <= '0; // rdee loads this word while stb is low
      else if (sram_stb)
         dsram <= mem[adr]; // Held until the next strobe
   end

   // ==================================================
   // Acknowledge
   // ==================================================

   // Fixed latency without wait states
   always_ff @(posedge clk) begin
      if (reset)
         sram_ack <= 1'b0;
      else
         sram_ack <= sram_stb;
   end

endmodule

// ==== logic/input_mux.sv ====
/*
 * Input mux of the core datapath. Chooses between the operand RAM word,
 * the registered read data and the right-shifted address. Also decodes the
 * system-register region, acknowledges it and registers the read word.
 */
`timescale 1ns/1ps

module input_mux #(
   parameter int IWIDTH = 8 // External input width, 1 to 32
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [inmux_pkg::DATA_W-1:0] dat_o,    // Operand RAM output
   input  logic [IWIDTH-1:0]            dat_i,    // External input port
   input  logic [inmux_pkg::DATA_W-1:0] dsram,    // SRAM read word
   input  logic [inmux_pkg::DATA_W-1:0] adr,      // Bus address
   input  logic                         sra_msb,  // Msb for the shifted address
   input  logic                         sa00,     // Sequencer select
   input  logic                         stb,      // Bus strobe for IO and sysregs
   input  logic                         sram_ack, // SRAM acknowledge
   input  logic                         io_ack,   // External bus acknowledge
   input  logic                         mie,
   input  logic                         mpie,
   input  logic                         msie,
   input  logic                         mtie,
   input  logic                         meie,
   input  logic                         mtimeincie,
   input  logic                         mrinstretie,
   input  logic                         msip,
   input  logic                         mtip,
   input  logic                         meip,
   input  logic                         mtimeincip,
   input  logic                         mrinstretip,
   output logic                         sysregack, // MIP/MIE/MSTATUS access
   output logic [inmux_pkg::DATA_W-1:0] di,        // Into the datapath
   output logic [inmux_pkg::DATA_W-1:0] rdee       // Registered read data
);
   import inmux_pkg::*;

   logic [DATA_W-1:0] ext_in;      // dat_i zero-extended
   logic [DATA_W-1:0] mip_word;
   logic [DATA_W-1:0] mie_word;
   logic [DATA_W-1:0] mstatus_word;
   logic [DATA_W-1:0] theio;       // Selected IO or sysreg word
   logic [DATA_W-1:0] sh_adr;      // Address shifted right by one
   logic              sys_hit;     // Region is a system register
   logic              sa00mod;     // Registered di select
   sysreg_sel_e       sel;

   // ==================================================
   // Register images
   // ==================================================

   always_comb begin
      ext_in              = '0;
      ext_in[IWIDTH-1:0]  = dat_i;

      mip_word             = '0;
      mip_word[BIT_SW]     = msip;
      mip_word[BIT_TIMER]  = mtip;
      mip_word[BIT_EXT]    = meip;
      mip_word[BIT_TICK]   = mtimeincip;
      mip_word[BIT_RETIRE] = mrinstretip;

      mie_word             = '0;
      mie_word[BIT_SW]     = msie;
      mie_word[BIT_TIMER]  = mtie;
      mie_word[BIT_EXT]    = meie;
      mie_word[BIT_TICK]   = mtimeincie;
      mie_word[BIT_RETIRE] = mrinstretie;

      mstatus_word            = MSTATUS_FIXED; // MPP reads as machine mode
      mstatus_word[BIT_SW]    = mie;
      mstatus_word[BIT_TIMER] = mpie;
   end

   // ==================================================
   // Region decode
   // ==================================================

   assign sel = sysreg_sel_e'(adr[29:27]);

   always_comb begin
      case (sel)
         IO0, IO1, IO2, IO3: begin
            theio   = ext_in;
            sys_hit = 1'b0;
         end
         MIP_ALT, MIP: begin
            theio   = mip_word; // Spare code aliases MIP
            sys_hit = 1'b1;
         end
         MIE: begin
            theio   = mie_word;
            sys_hit = 1'b1;
         end
         default: begin
            theio   = mstatus_word; // MSTATUS
            sys_hit = 1'b1;
         end
      endcase
   end

   assign sysregack = stb & sys_hit; // Same-cycle ack, no wait state

   // ==================================================
   // Registered read data and select
   // ==================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         rdee    <= '0;
         sa00mod <= 1'b0;
      end else begin
         rdee    <= stb ? theio : dsram; // SRAM word when no bus strobe
         sa00mod <= io_ack | sysregack | sram_ack | sa00;
      end
   end

   // Bitwise merge, dat_o picks rdee where set and shifted address where clear
   assign sh_adr = {sra_msb, adr[DATA_W-1:1]};
   assign di     = sa00mod ? ((dat_o & rdee) | (~dat_o & sh_adr)) : dat_o;

endmodule

// ==== logic/inmux_top.sv ====
/*
 * Data-input side of the core. Connects the SRAM, the interrupt bits and
 * the input mux. Sequencer and operand RAM signals come in as plain ports.
 */
`timescale 1ns/1ps

module inmux_top #(
   parameter int IWIDTH     = 8, // External input width
   parameter int SRAM_ADR_W = 6  // SRAM word address bits
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [inmux_pkg::DATA_W-1:0] dat_o,        // Operand RAM output
   input  logic [IWIDTH-1:0]            dat_i,        // External input port
   input  logic [inmux_pkg::DATA_W-1:0] adr,          // Byte address
   input  logic                         sra_msb,
   input  logic                         sa00,
   input  logic                         stb,          // IO and sysreg strobe
   input  logic                         sram_stb,     // SRAM strobe
   input  logic                         we,
   input  logic [inmux_pkg::DATA_W-1:0] wdat,
   input  logic                         io_ack,
   input  logic                         irq_ext,
   input  logic                         irq_timer,
   input  logic                         tick_pulse,
   input  logic                         retire_pulse,
   output logic [inmux_pkg::DATA_W-1:0] di,
   output logic [inmux_pkg::DATA_W-1:0] rdee,
   output logic                         sysregack,
   output logic                         sram_ack,
   output logic                         irq_pending
);

   logic [inmux_pkg::DATA_W-1:0] dsram;
   // Interrupt bits between irq_csr_bits and input_mux
   logic mie, mpie;
   logic msie, mtie, meie, mtimeincie, mrinstretie;
   logic msip, mtip, meip, mtimeincip, mrinstretip;

   // ==================================================
   // SRAM, word addressed from adr[SRAM_ADR_W+1:2]
   // ==================================================

   data_sram #(
      .SRAM_ADR_W (SRAM_ADR_W)
   ) u_data_sram (
      .clk      (clk),
      .reset    (reset),
      .sram_stb (sram_stb),
      .we       (we),
      .adr      (adr[SRAM_ADR_W+1:2]),
      .wdat     (wdat),
      .dsram    (dsram),
      .sram_ack (sram_ack)
   );

   irq_csr_bits u_irq_csr_bits (
      .clk          (clk),
      .reset        (reset),
      .sysregack    (sysregack),   // Write only after the mux acks
      .we           (we),
      .adr          (adr[28:27]),
      .wdat         (wdat),
      .irq_ext      (irq_ext),
      .irq_timer    (irq_timer),
      .tick_pulse   (tick_pulse),
      .retire_pulse (retire_pulse),
      .mie          (mie),
      .mpie         (mpie),
      .msie         (msie),
      .mtie         (mtie),
      .meie         (meie),
      .mtimeincie   (mtimeincie),
      .mrinstretie  (mrinstretie),
      .msip         (msip),
      .mtip         (mtip),
      .meip         (meip),
      .mtimeincip   (mtimeincip),
      .mrinstretip  (mrinstretip),
      .irq_pending  (irq_pending)
   );

   input_mux #(
      .IWIDTH (IWIDTH)
   ) u_input_mux (
      .clk         (clk),
      .reset       (reset),
      .dat_o       (dat_o),
      .dat_i       (dat_i),
      .dsram       (dsram),
      .adr         (adr),
      .sra_msb     (sra_msb),
      .sa00        (sa00),
      .stb         (stb),
      .sram_ack    (sram_ack),
      .io_ack      (io_ack),
      .mie         (mie),
      .mpie        (mpie),
      .msie        (msie),
      .mtie        (mtie),
      .meie        (meie),
      .mtimeincie  (mtimeincie),
      .mrinstretie (mrinstretie),
      .msip        (msip),
      .mtip        (mtip),
      .meip        (meip),
      .mtimeincip  (mtimeincip),
      .mrinstretip (mrinstretip),
      .sysregack   (sysregack),
      .di          (di),
      .rdee        (rdee)
   );

endmodule

// ==== testbench/inmux_assertions.sv ====
/*
 * Concurrent checks on acknowledge and reset behaviour of the data-input side.
 * Bound into inmux_top. The testbench reads the failure count at the end.
 */
`timescale 1ns/1ps

module inmux_assertions (
   input logic                         clk,
   input logic                         reset,
   input logic                         stb,        // IO and sysreg strobe
   input logic                         sys_region, // adr[29] selects MIP, MIE or MSTATUS
   input logic                         sysregack,
   input logic                         sram_stb,
   input logic                         sram_ack,
   input logic                         sel_q,      // Registered di select of the mux
   input logic [inmux_pkg::DATA_W-1:0] rdee
);

   int err_count = 0; // Failed assertions so far

   // ==================================================
   // Handshakes
   // ==================================================

   // Ack only for a strobe on a system-register code and never without stb
   a_ack_decode: assert property (@(posedge clk) disable iff (reset)
                                  sysregack == (stb && sys_region))
      else begin
         err_count++;
         $error("sysregack does not match stb on a system-register code");
      end

   // SRAM acknowledge exactly one cycle behind the strobe
   a_sram_ack_follows: assert property (@(posedge clk) disable iff (reset) sram_stb |=> sram_ack)
      else begin
         err_count++;
         $error("sram_ack missing one cycle after sram_stb");
      end

   a_sram_ack_only: assert property (@(posedge clk) disable iff (reset) !sram_stb |=> !sram_ack)
      else begin
         err_count++;
         $error("sram_ack without a strobe in the cycle before");
      end

   // ==================================================
   // Reset
   // ==================================================

   a_reset_clears: assert property (@(posedge clk) $fell(reset) |-> (!sel_q && rdee == '0))
      else begin
         err_count++;
         $error("select register or rdee not cleared by reset");
      end

endmodule

bind inmux_top inmux_assertions u_inmux_assertions (
   .clk        (clk),
   .reset      (reset),
   .stb        (stb),
   .sys_region (adr[29]),
   .sysregack  (sysregack),
   .sram_stb   (sram_stb),
   .sram_ack   (sram_ack),
   .sel_q      (u_input_mux.sa00mod),
   .rdee       (rdee)
);

// ==== testbench/inmux_tb.sv ====
/*
 * Directed testbench for the data-input side of the core.
 * Runs reset, IO, sysreg, SRAM, di merge and interrupt tests in sequence.
 */
`timescale 1ns/1ps

module inmux_tb;
   import inmux_pkg::*;

   localparam int          IWIDTH    = 8;
   localparam int          CLK_HALF  = 5;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // Taps 32, 22, 2, 1
   // Defined bits of MIE and the writable bits of MSTATUS
   localparam logic [DATA_W-1:0] IRQ_MASK = (32'h1 << BIT_SW) | (32'h1 << BIT_TIMER)
                                          | (32'h1 << BIT_EXT) | (32'h1 << BIT_TICK)
                                          | (32'h1 << BIT_RETIRE);
   localparam logic [DATA_W-1:0] STATUS_RW = (32'h1 << BIT_SW) | (32'h1 << BIT_TIMER);
   // Cycle budgets of the reset, io, sysreg, sram, select and irq tests
   localparam int RUN_CYCLES    = 10 + 40 + 70 + 60 + 20 + 70;
   localparam int MARGIN_CYCLES = 200;

   logic              clk = 1'b0;
   logic              reset;
   logic [DATA_W-1:0] dat_o, adr, wdat;
   logic [IWIDTH-1:0] dat_i;
   logic              sra_msb, sa00, stb, sram_stb, we, io_ack;
   logic              irq_ext, irq_timer, tick_pulse, retire_pulse;
   logic [DATA_W-1:0] di, rdee;
   logic              sysregack, sram_ack, irq_pending;

   logic [31:0]       lfsr = 32'h32f3_103c;
   logic [DATA_W-1:0] last_sram; // Word held in dsram after the SRAM test
   int                errors = 0;
   int                tests_run = 0;
   int                tests_failed = 0;

   inmux_top #(.IWIDTH(IWIDTH), .SRAM_ADR_W(6)) u_inmux_top (
      .clk(clk), .reset(reset), .dat_o(dat_o), .dat_i(dat_i), .adr(adr),
      .sra_msb(sra_msb), .sa00(sa00), .stb(stb), .sram_stb(sram_stb), .we(we),
      .wdat(wdat), .io_ack(io_ack), .irq_ext(irq_ext), .irq_timer(irq_timer),
      .tick_pulse(tick_pulse), .retire_pulse(retire_pulse), .di(di), .rdee(rdee),
      .sysregack(sysregack), .sram_ack(sram_ack), .irq_pending(irq_pending)
   );

   always #CLK_HALF clk = ~clk;

   // Watchdog
   initial begin
      #((RUN_CYCLES + MARGIN_CYCLES) * 2 * CLK_HALF);
      $display("Watchdog expired, the tests did not complete in time");
      $display("*** TEST FAILED ***");
      $finish;
   end

   // ==================================================
   // Helpers
   // ==================================================

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [31:0] sysreg_addr(input sysreg_sel_e s);
      logic [31:0] r;
      r = rand_bits(29); // Bits outside 29:27 are don't care
      return {r[28:27], s, r[26:0]};
   endfunction

   // Per bit dat_o set takes rdee and clear takes the shifted address
   function automatic logic [31:0] merge_expect(input logic [31:0] d, rd, sh);
      logic [31:0] r;
      for (int b = 0; b < DATA_W; b++)
         r[b] = d[b] ? rd[b] : sh[b];
      return r;
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] got, exp);
      $display("Error %s: got %08h, expected %08h at %0t", sig, got, exp, $time);
      errors++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("%-14s ok", name);
      end else begin
         tests_failed++;
         $display("%-14s FAILED with %0d errors", name, errors - errs_before);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      @(negedge clk);
   endtask

   // IO or sysreg read with the word sampled at the second edge
   task automatic bus_read(input logic [31:0] a, input logic exp_ack, output logic [31:0] rd);
      @(posedge clk);
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= a;
      @(negedge clk);
      if (sysregack !== exp_ack) report_mismatch("sysregack", sysregack, exp_ack);
      @(posedge clk);
      stb <= 1'b0;
      @(negedge clk);
      rd = rdee;
   endtask

   task automatic bus_write(input logic [31:0] a, input logic [31:0] w);
      @(posedge clk);
      stb  <= 1'b1;
      we   <= 1'b1;
      adr  <= a;
      wdat <= w;
      @(negedge clk);
      if (sysregack !== 1'b1) report_mismatch("sysregack", sysregack, 1'b1);
      @(posedge clk);
      stb <= 1'b0;
      we  <= 1'b0;
      @(negedge clk);
   endtask

   // One SRAM access with the ack checked before, during and after its cycle
   task automatic sram_access(input logic wr, input logic [5:0] wa, input logic [31:0] w);
      @(posedge clk);
      sram_stb <= 1'b1;
      we       <= wr;
      adr      <= {24'h0, wa, 2'b00};
      wdat     <= w;
      @(negedge clk);
      if (sram_ack !== 1'b0) report_mismatch("sram_ack", sram_ack, 1'b0);
      @(posedge clk);
      sram_stb <= 1'b0;
      we       <= 1'b0;
      @(negedge clk);
      if (sram_ack !== 1'b1) report_mismatch("sram_ack", sram_ack, 1'b1);
      wait_cycles(1); // rdee picks up dsram here
      if (sram_ack !== 1'b0) report_mismatch("sram_ack", sram_ack, 1'b0);
   endtask

   // ==================================================
   // Tests
   // ==================================================

   task automatic test_reset();
      int e0;
      e0 = errors;
      @(posedge clk);
      dat_o <= rand_bits(32);
      @(negedge clk);
      if (sysregack !== 1'b0) report_mismatch("sysregack", sysregack, 1'b0);
      if (sram_ack !== 1'b0) report_mismatch("sram_ack", sram_ack, 1'b0);
      if (irq_pending !== 1'b0) report_mismatch("irq_pending", irq_pending, 1'b0);
      if (rdee !== '0) report_mismatch("rdee", rdee, '0);
      if (di !== dat_o) report_mismatch("di", di, dat_o); // Select still clear
      finish_test("reset_state", e0);
   endtask

   task automatic test_ext_input();
      int          e0;
      logic [31:0] a, r, rd;
      logic [7:0]  din;
      e0 = errors;
      for (int n = 0; n < 8; n++) begin
         r   = rand_bits(31);
         din = rand_bits(8);
         a   = {r[30:29], 1'b0, r[28:0]}; // adr[29] low selects IO0 to IO3
         @(posedge clk);
         dat_i <= din;
         bus_read(a, 1'b0, rd);
         if (rd !== {24'h0, din}) report_mismatch("rdee", rd, {24'h0, din});
      end
      finish_test("ext_input", e0);
   endtask

   task automatic test_sysregs();
      int          e0;
      logic [31:0] w, rd;
      e0 = errors;
      for (int n = 0; n < 3; n++) begin
         w = rand_bits(32);
         bus_write(sysreg_addr(MIE), w);
         bus_read(sysreg_addr(MIE), 1'b1, rd);
         if (rd !== (w & IRQ_MASK)) report_mismatch("rdee", rd, w & IRQ_MASK);
         w = rand_bits(32);
         bus_write(sysreg_addr(MSTATUS), w);
         bus_read(sysreg_addr(MSTATUS), 1'b1, rd);
         if (rd !== ((w & STATUS_RW) | MSTATUS_FIXED))
            report_mismatch("rdee", rd, (w & STATUS_RW) | MSTATUS_FIXED);
         if ((rd & MSTATUS_FIXED) !== MSTATUS_FIXED)
            report_mismatch("mstatus fixed bits", rd & MSTATUS_FIXED, MSTATUS_FIXED);
      end
      // Latch a tick, read through the alias, then clear it
      @(posedge clk);
      tick_pulse <= 1'b1;
      @(posedge clk);
      tick_pulse <= 1'b0;
      bus_read(sysreg_addr(MIP_ALT), 1'b1, rd);
      if (rd !== (32'h1 << BIT_TICK)) report_mismatch("rdee", rd, 32'h1 << BIT_TICK);
      bus_write(sysreg_addr(MIP), 32'h0);
      bus_read(sysreg_addr(MIP), 1'b1, rd);
      if (rd !== 32'h0) report_mismatch("rdee", rd, 32'h0);
      bus_write(sysreg_addr(MSTATUS), 32'h0);
      bus_write(sysreg_addr(MIE), 32'h0);
      finish_test("sysregs", e0);
   endtask

   task automatic test_sram();
      int          e0;
      logic [5:0]  wa [6];
      logic [31:0] wd [6];
      logic [31:0] r;
      e0 = errors;
      for (int i = 0; i < 6; i++) begin
         r     = rand_bits(3);
         wa[i] = {i[2:0], r[2:0]}; // Upper bits keep addresses distinct
         wd[i] = rand_bits(32);
         sram_access(1'b1, wa[i], wd[i]);
      end
      for (int i = 0; i < 6; i++) begin
         sram_access(1'b0, wa[i], 32'h0);
         if (rdee !== wd[i]) report_mismatch("rdee", rdee, wd[i]);
      end
      last_sram = wd[5];
      finish_test("sram", e0);
   endtask

   task automatic test_select();
      int          e0;
      logic [31:0] a, d, exp;
      logic        m;
      e0 = errors;
      a = rand_bits(32);
      m = rand_bits(1);
      d = rand_bits(32);
      repeat (2) @(posedge clk); // Let the last SRAM ack leave the select
      dat_o   <= d;
      adr     <= a;
      sra_msb <= m;
      @(negedge clk);
      if (di !== d) report_mismatch("di", di, d);
      // sa00 with dat_o all ones gives rdee
      @(posedge clk);
      sa00  <= 1'b1;
      dat_o <= '1;
      @(negedge clk);
      if (di !== '1) report_mismatch("di", di, '1);
      @(posedge clk);
      sa00 <= 1'b0;
      @(negedge clk);
      if (di !== last_sram) report_mismatch("di", di, last_sram);
      // io_ack with dat_o all zeros gives the shifted address
      @(posedge clk);
      io_ack <= 1'b1;
      dat_o  <= '0;
      @(posedge clk);
      io_ack <= 1'b0;
      @(negedge clk);
      if (di !== {m, a[31:1]}) report_mismatch("di", di, {m, a[31:1]});
      // Mixed dat_o and then the select drops again
      @(posedge clk);
      sa00  <= 1'b1;
      dat_o <= d;
      @(posedge clk);
      sa00 <= 1'b0;
      @(negedge clk);
      exp = merge_expect(d, last_sram, {m, a[31:1]});
      if (di !== exp) report_mismatch("di", di, exp);
      wait_cycles(1);
      if (di !== d) report_mismatch("di", di, d);
      finish_test("select", e0);
   endtask

   task automatic test_irq();
      int e0;
      e0 = errors;
      bus_write(sysreg_addr(MIP), 32'h0);
      @(posedge clk);
      irq_timer <= 1'b1; // Pending but not enabled
      wait_cycles(3);
      if (irq_pending !== 1'b0) report_mismatch("irq_pending", irq_pending, 1'b0);
      bus_write(sysreg_addr(MIE), 32'h1 << BIT_TIMER);
      wait_cycles(3); // Enabled but mie still clear
      if (irq_pending !== 1'b0) report_mismatch("irq_pending", irq_pending, 1'b0);
      bus_write(sysreg_addr(MSTATUS), 32'h1 << BIT_SW);
      if (irq_pending !== 1'b0) report_mismatch("irq_pending", irq_pending, 1'b0);
      wait_cycles(1);
      if (irq_pending !== 1'b1) report_mismatch("irq_pending", irq_pending, 1'b1);
      @(posedge clk);
      irq_timer <= 1'b0; // Source removed
      wait_cycles(2);
      if (irq_pending !== 1'b0) report_mismatch("irq_pending", irq_pending, 1'b0);
      // Retire event latched until cleared
      bus_write(sysreg_addr(MIE), 32'h1 << BIT_RETIRE);
      @(posedge clk);
      retire_pulse <= 1'b1;
      @(posedge clk);
      retire_pulse <= 1'b0;
      wait_cycles(2);
      if (irq_pending !== 1'b1) report_mismatch("irq_pending", irq_pending, 1'b1);
      bus_write(sysreg_addr(MIP), 32'h0);
      wait_cycles(1);
      if (irq_pending !== 1'b0) report_mismatch("irq_pending", irq_pending, 1'b0);
      bus_write(sysreg_addr(MSTATUS), 32'h0);
      finish_test("interrupts", e0);
   endtask

   // ==================================================
   // Main sequence
   // ==================================================

   initial begin
      reset        = 1'b1;
      dat_o        = '0;
      dat_i        = '0;
      adr          = '0;
      wdat         = '0;
      sra_msb      = 1'b0;
      sa00         = 1'b0;
      stb          = 1'b0;
      sram_stb     = 1'b0;
      we           = 1'b0;
      io_ack       = 1'b0;
      irq_ext      = 1'b0;
      irq_timer    = 1'b0;
      tick_pulse   = 1'b0;
      retire_pulse = 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);

      test_reset();
      test_ext_input();
      test_sysregs();
      test_sram();
      test_select();
      test_irq();

      $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion errors",
               tests_run, tests_failed, errors, u_inmux_top.u_inmux_assertions.err_count);
      if (errors == 0 && tests_failed == 0 && u_inmux_top.u_inmux_assertions.err_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== list.f ====
logic/inmux_pkg.sv
logic/irq_csr_bits.sv
logic/data_sram.sv
logic/input_mux.sv
logic/inmux_top.sv
testbench/inmux_assertions.sv
testbench/inmux_tb.sv

// ==== Bender.yml ====
package:
  name: inmux

sources:
  - files:
      - logic/inmux_pkg.sv
      - logic/irq_csr_bits.sv
      - logic/data_sram.sv
      - logic/input_mux.sv
      - logic/inmux_top.sv
  - target: simulation
    files:
      - testbench/inmux_assertions.sv
      - testbench/inmux_tb.sv
